// File: source/rv_isa_pkg.sv
`default_nettype none

package rv_isa_pkg;

    // Base architecture
    localparam int XLEN       = 32;
    localparam int REG_ADDR_W = 5;
    localparam int OPCODE_W   = 7;

    // Data, instruction and address word
    typedef logic [XLEN-1:0]       xlen_t;
    // Register index as it appears in rd, rs1 and rs2
    typedef logic [REG_ADDR_W-1:0] reg_addr_t;
    // Major opcode, inst[6:0]
    typedef logic [OPCODE_W-1:0]   opcode_t;

    // RV32I major opcodes
    localparam opcode_t OPC_LUI    = 7'b0110111;
    localparam opcode_t OPC_AUIPC  = 7'b0010111;
    localparam opcode_t OPC_JAL    = 7'b1101111;
    localparam opcode_t OPC_JALR   = 7'b1100111;
    localparam opcode_t OPC_BRANCH = 7'b1100011;
    localparam opcode_t OPC_LOAD   = 7'b0000011;
    localparam opcode_t OPC_STORE  = 7'b0100011;
    localparam opcode_t OPC_OP_IMM = 7'b0010011;
    localparam opcode_t OPC_OP     = 7'b0110011;
    localparam opcode_t OPC_SYSTEM = 7'b1110011;

    // Sequential pc increment
    localparam xlen_t PC_STEP  = 32'h0000_0004;
    // Boot address of the core
    localparam xlen_t RESET_PC = 32'h8000_0000;

endpackage : rv_isa_pkg

`default_nettype wire

// File: source/wb_pkg.sv
`default_nettype none

package wb_pkg;

    // Source of the register write data
    typedef logic [1:0] wb_sel_t;

    localparam wb_sel_t WB_NONE = 2'b00;
    localparam wb_sel_t WB_PC4  = 2'b01;
    localparam wb_sel_t WB_ALU  = 2'b10;
    localparam wb_sel_t WB_LOAD = 2'b11;

    // Commit FSM
    // HOLD waits for mem_valid_i to drop after a commit
    typedef enum logic [1:0] {
        WB_IDLE   = 2'b00,
        WB_COMMIT = 2'b01,
        WB_HOLD   = 2'b10
    } wb_state_e;

    // Finished instruction from the memory stage, 133 bits
    typedef struct packed {
        rv_isa_pkg::xlen_t     pc;
        rv_isa_pkg::xlen_t     inst;
        rv_isa_pkg::xlen_t     result;
        rv_isa_pkg::xlen_t     dmem_rdata;
        rv_isa_pkg::reg_addr_t rd;
    } mem_wb_t;

    // Register file write port, 38 bits
    typedef struct packed {
        logic                  we;
        rv_isa_pkg::reg_addr_t addr;
        rv_isa_pkg::xlen_t     data;
    } rf_wr_t;

endpackage : wb_pkg

`default_nettype wire

// File: source/wb_decode.sv
`timescale 1ns/10ps
`default_nettype none

module wb_decode (
    input  wire rv_isa_pkg::opcode_t opcode_i,
    output logic                     rf_we_o,
    output wb_pkg::wb_sel_t          wb_sel_o
);

    // Only the major opcode matters for write-back
    always_comb begin
        case (opcode_i)
            // ALU result classes
            rv_isa_pkg::OPC_LUI,
            rv_isa_pkg::OPC_AUIPC,
            rv_isa_pkg::OPC_OP,
            rv_isa_pkg::OPC_OP_IMM: begin
                rf_we_o  = 1'b1;
                wb_sel_o = wb_pkg::WB_ALU;
            end

            rv_isa_pkg::OPC_LOAD: begin
                rf_we_o  = 1'b1;
                wb_sel_o = wb_pkg::WB_LOAD;
            end

            // Link register gets the return address
            rv_isa_pkg::OPC_JAL,
            rv_isa_pkg::OPC_JALR: begin
                rf_we_o  = 1'b1;
                wb_sel_o = wb_pkg::WB_PC4;
            end

            // No destination register
            rv_isa_pkg::OPC_BRANCH,
            rv_isa_pkg::OPC_STORE,
            rv_isa_pkg::OPC_SYSTEM: begin
                rf_we_o  = 1'b0;
                wb_sel_o = wb_pkg::WB_NONE;
            end

            // Unknown opcodes never touch the register file
            default: begin
                rf_we_o  = 1'b0;
                wb_sel_o = wb_pkg::WB_NONE;
            end
        endcase
    end

endmodule : wb_decode

`default_nettype wire

// File: source/wb_stage.sv
`timescale 1ns/10ps
`default_nettype none

module wb_stage (
    input  wire             clk,
    input  wire             rst,
    // From the memory stage
    input  wb_pkg::mem_wb_t mem_wb_i,
    input  wire             mem_valid_i,
    // To the register file
    output wb_pkg::rf_wr_t  rf_wr_o,
    // To fetch
    output logic            pc_wen_o
);

    wb_pkg::wb_state_e   state;
    wb_pkg::wb_state_e   state_nxt;
    wb_pkg::mem_wb_t     wb_q;
    logic                capture;

    rv_isa_pkg::opcode_t opcode;
    logic                rf_we_raw;
    wb_pkg::wb_sel_t     wb_sel;
    rv_isa_pkg::xlen_t   pc_plus4;
    rv_isa_pkg::xlen_t   wr_data;

    // New instruction is taken only from IDLE
    assign capture = (state == wb_pkg::WB_IDLE) && mem_valid_i;

    // Commit FSM
    always_comb begin
        state_nxt = state;
        case (state)
            wb_pkg::WB_IDLE: begin
                if (mem_valid_i) begin
                    state_nxt = wb_pkg::WB_COMMIT;
                end
            end
            wb_pkg::WB_COMMIT: begin
                // A still-high valid belongs to the same instruction
                state_nxt = mem_valid_i ? wb_pkg::WB_HOLD : wb_pkg::WB_IDLE;
            end
            wb_pkg::WB_HOLD: begin
                if (!mem_valid_i) begin
                    state_nxt = wb_pkg::WB_IDLE;
                end
            end
            default: begin
                state_nxt = wb_pkg::WB_IDLE;
            end
        endcase
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state <= wb_pkg::WB_IDLE;
        end else begin
            state <= state_nxt;
        end
    end

    // Capture registers
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            wb_q.pc         <= rv_isa_pkg::RESET_PC;
            wb_q.inst       <= '0;
            wb_q.result     <= '0;
            wb_q.dmem_rdata <= '0;
            wb_q.rd         <= '0;
        end else if (capture) begin
            wb_q <= mem_wb_i;
        end
    end

    // Decode from the captured instruction word
    assign opcode = wb_q.inst[6:0];

    wb_decode u_decode (
        .opcode_i (opcode),
        .rf_we_o  (rf_we_raw),
        .wb_sel_o (wb_sel)
    );

    assign pc_plus4 = wb_q.pc + rv_isa_pkg::PC_STEP;

    // Write data source
    always_comb begin
        case (wb_sel)
            wb_pkg::WB_PC4:  wr_data = pc_plus4;
            wb_pkg::WB_ALU:  wr_data = wb_q.result;
            wb_pkg::WB_LOAD: wr_data = wb_q.dmem_rdata;
            default:         wr_data = '0;
        endcase
    end

    // One commit cycle per instruction
    assign pc_wen_o = (state == wb_pkg::WB_COMMIT);

    // x0 is never written, suppressed here
    assign rf_wr_o.we   = pc_wen_o && rf_we_raw && (wb_q.rd != '0);
    assign rf_wr_o.addr = wb_q.rd;
    assign rf_wr_o.data = wr_data;

endmodule : wb_stage

`default_nettype wire

// File: source/reg_file.sv
`timescale 1ns/10ps
`default_nettype none

module reg_file #(
    // 32 for RV32I, 16 for RV32E
    parameter int NUM_REGS = 32
) (
    input  wire                       clk,
    input  wire                       rst,
    // Write port from write-back
    input  wb_pkg::rf_wr_t            rf_wr_i,
    // Read ports
    input  wire rv_isa_pkg::reg_addr_t rs1_addr_i,
    input  wire rv_isa_pkg::reg_addr_t rs2_addr_i,
    output rv_isa_pkg::xlen_t         rs1_data_o,
    output rv_isa_pkg::xlen_t         rs2_data_o
);

    rv_isa_pkg::xlen_t regs [NUM_REGS];

    logic wr_in_range;
    logic rs1_valid;
    logic rs2_valid;

    assign wr_in_range = (int'(rf_wr_i.addr) < NUM_REGS);

    // Synchronous write, indices past the top are dropped
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            for (int i = 0; i < NUM_REGS; i++) begin
                regs[i] <= '0;
            end
        end else if (rf_wr_i.we && wr_in_range) begin
            regs[rf_wr_i.addr] <= rf_wr_i.data;
        end
    end

    // x0 and missing registers read as zero
    assign rs1_valid = (rs1_addr_i != '0) && (int'(rs1_addr_i) < NUM_REGS);
    assign rs2_valid = (rs2_addr_i != '0) && (int'(rs2_addr_i) < NUM_REGS);

    always_comb begin
        if (rs1_valid) begin
            rs1_data_o = regs[rs1_addr_i];
        end else begin
            rs1_data_o = '0;
        end
    end

    always_comb begin
        if (rs2_valid) begin
            rs2_data_o = regs[rs2_addr_i];
        end else begin
            rs2_data_o = '0;
        end
    end

endmodule : reg_file

`default_nettype wire

// File: source/wb_top.sv
`timescale 1ns/10ps
`default_nettype none

module wb_top #(
    parameter int NUM_REGS = 32
) (
    input  wire                        clk,
    input  wire                        rst,
    // Memory stage handoff
    input  wb_pkg::mem_wb_t            mem_wb_i,
    input  wire                        mem_valid_i,
    // Register read ports
    input  wire rv_isa_pkg::reg_addr_t rs1_addr_i,
    input  wire rv_isa_pkg::reg_addr_t rs2_addr_i,
    output rv_isa_pkg::xlen_t          rs1_data_o,
    output rv_isa_pkg::xlen_t          rs2_data_o,
    // Fetch may advance
    output logic                       pc_wen_o
);

    wb_pkg::rf_wr_t rf_wr;

    wb_stage u_wb_stage (
        .clk         (clk),
        .rst         (rst),
        .mem_wb_i    (mem_wb_i),
        .mem_valid_i (mem_valid_i),
        .rf_wr_o     (rf_wr),
        .pc_wen_o    (pc_wen_o)
    );

    reg_file #(
        .NUM_REGS (NUM_REGS)
    ) u_reg_file (
        .clk        (clk),
        .rst        (rst),
        .rf_wr_i    (rf_wr),
        .rs1_addr_i (rs1_addr_i),
        .rs2_addr_i (rs2_addr_i),
        .rs1_data_o (rs1_data_o),
        .rs2_data_o (rs2_data_o)
    );

endmodule : wb_top

`default_nettype wire

// File: sim/wb_chk.sv
`timescale 1ns/10ps
`default_nettype none

module wb_chk (
    input wire            clk,
    input wire            rst,
    input wire            pc_wen_i,
    input wb_pkg::rf_wr_t rf_wr_i
);

    // Number of failed assertions, read by the testbench at the end
    int unsigned fail_cnt;

    initial fail_cnt = 0;

    // Commit lasts a single cycle
    pc_wen_single: assert property (@(posedge clk) disable iff (rst)
        pc_wen_i |=> !pc_wen_i)
    else begin
        fail_cnt++;
        $error("pc_wen_o stayed high for more than one cycle");
    end

    // Register writes happen only in the commit cycle
    we_in_commit: assert property (@(posedge clk) disable iff (rst)
        rf_wr_i.we |-> pc_wen_i)
    else begin
        fail_cnt++;
        $error("register write outside the commit cycle");
    end

    // x0 is never a write target
    we_not_x0: assert property (@(posedge clk) disable iff (rst)
        rf_wr_i.we |-> (rf_wr_i.addr != '0))
    else begin
        fail_cnt++;
        $error("register write to x0");
    end

endmodule : wb_chk

bind wb_stage wb_chk u_chk (
    .clk      (clk),
    .rst      (rst),
    .pc_wen_i (pc_wen_o),
    .rf_wr_i  (rf_wr_o)
);

`default_nettype wire

// File: sim/wb_tb.sv
`timescale 1ns/10ps
`default_nettype none

module wb_tb;

    localparam int NUM_REGS = 32;
    localparam int TIMEOUT  = 50;

    logic                  clk;
    logic                  rst;
    wb_pkg::mem_wb_t       mem_wb;
    logic                  mem_valid;
    rv_isa_pkg::reg_addr_t rs1_addr;
    rv_isa_pkg::reg_addr_t rs2_addr;
    rv_isa_pkg::xlen_t     rs1_data;
    rv_isa_pkg::xlen_t     rs2_data;
    logic                  pc_wen;

    // Expected register contents
    rv_isa_pkg::xlen_t model_regs [32];

    int    n_checks;
    int    n_errors;
    int    n_tests;
    int    n_failed;
    int    err_at_start;
    string test_name;
    logic  hung;

    wb_top #(
        .NUM_REGS (NUM_REGS)
    ) UUT (
        .clk         (clk),
        .rst         (rst),
        .mem_wb_i    (mem_wb),
        .mem_valid_i (mem_valid),
        .rs1_addr_i  (rs1_addr),
        .rs2_addr_i  (rs2_addr),
        .rs1_data_o  (rs1_data),
        .rs2_data_o  (rs2_data),
        .pc_wen_o    (pc_wen)
    );

    always #2 clk = ~clk;

    task automatic check_xlen(string what, rv_isa_pkg::xlen_t exp, rv_isa_pkg::xlen_t act);
        n_checks++;
        if (act !== exp) begin
            n_errors++;
            $display("FAIL %s: expected %08h, actual %08h", what, exp, act);
        end
    endtask

    task automatic check_bit(string what, logic exp, logic act);
        n_checks++;
        if (act !== exp) begin
            n_errors++;
            $display("FAIL %s: expected %b, actual %b", what, exp, act);
        end
    endtask

    task automatic start_test(string name);
        test_name    = name;
        err_at_start = n_errors;
        n_tests++;
    endtask

    task automatic end_test();
        if (!hung && n_errors == err_at_start) begin
            $display("[%0t] %s passed", $time, test_name);
        end else begin
            n_failed++;
            $display("[%0t] %s failed", $time, test_name);
        end
    endtask

    // 0..9 are the known classes, anything else gives a random opcode
    function automatic rv_isa_pkg::opcode_t opcode_at(int k);
        case (k)
            0: return rv_isa_pkg::OPC_LUI;
            1: return rv_isa_pkg::OPC_AUIPC;
            2: return rv_isa_pkg::OPC_OP;
            3: return rv_isa_pkg::OPC_OP_IMM;
            4: return rv_isa_pkg::OPC_LOAD;
            5: return rv_isa_pkg::OPC_JAL;
            6: return rv_isa_pkg::OPC_JALR;
            7: return rv_isa_pkg::OPC_BRANCH;
            8: return rv_isa_pkg::OPC_STORE;
            9: return rv_isa_pkg::OPC_SYSTEM;
            default: return rv_isa_pkg::opcode_t'($urandom());
        endcase
    endfunction

    function automatic rv_isa_pkg::xlen_t rand_pc();
        rv_isa_pkg::xlen_t pc;
        pc = $urandom();
        pc[1:0] = 2'b00;
        return pc;
    endfunction

    // Reference write-back rule
    function automatic void update_model(rv_isa_pkg::opcode_t opc, rv_isa_pkg::reg_addr_t rd,
                                         rv_isa_pkg::xlen_t pc, rv_isa_pkg::xlen_t result,
                                         rv_isa_pkg::xlen_t rdata);
        if (rd == 0) begin
            return;
        end
        if (opc == rv_isa_pkg::OPC_LUI || opc == rv_isa_pkg::OPC_AUIPC ||
            opc == rv_isa_pkg::OPC_OP || opc == rv_isa_pkg::OPC_OP_IMM) begin
            model_regs[rd] = result;
        end else if (opc == rv_isa_pkg::OPC_LOAD) begin
            model_regs[rd] = rdata;
        end else if (opc == rv_isa_pkg::OPC_JAL || opc == rv_isa_pkg::OPC_JALR) begin
            model_regs[rd] = pc + 32'd4;
        end
    endfunction

    // Hand over one instruction and wait for its commit
    task automatic issue_inst(rv_isa_pkg::opcode_t opc, rv_isa_pkg::reg_addr_t rd,
                              rv_isa_pkg::xlen_t pc, rv_isa_pkg::xlen_t result,
                              rv_isa_pkg::xlen_t rdata);
        rv_isa_pkg::xlen_t inst;
        int                waited;
        logic              seen;
        if (hung) begin
            return;
        end
        inst = $urandom();
        inst[6:0] = opc;
        @(posedge clk);
        #1;
        mem_wb.pc         = pc;
        mem_wb.inst       = inst;
        mem_wb.result     = result;
        mem_wb.dmem_rdata = rdata;
        mem_wb.rd         = rd;
        mem_valid         = 1'b1;
        seen   = 1'b0;
        waited = 0;
        while (!seen && waited < TIMEOUT) begin
            @(posedge clk);
            #1;
            seen = pc_wen;
            waited++;
        end
        mem_valid = 1'b0;
        if (!seen) begin
            hung = 1'b1;
            $display("ERROR: %s got no pc_wen_o pulse within %0d cycles", test_name, TIMEOUT);
            return;
        end
        check_bit({test_name, " pc_wen_o one edge after valid"}, 1'b1, logic'(waited == 1));
        // Target register still holds its old value in the commit cycle
        rs2_addr = rd;
        #1;
        check_xlen({test_name, " rd before commit edge"}, model_regs[rd], rs2_data);
        update_model(opc, rd, pc, result, rdata);
        // Register is written on this edge and the pulse ends
        @(posedge clk);
        #1;
        check_bit({test_name, " pc_wen_o after commit"}, 1'b0, pc_wen);
        check_xlen({test_name, " rd after commit edge"}, model_regs[rd], rs2_data);
    endtask

    task automatic check_reg(rv_isa_pkg::reg_addr_t rd, rv_isa_pkg::xlen_t exp);
        if (hung) begin
            return;
        end
        @(posedge clk);
        #1;
        rs1_addr = rd;
        #1;
        check_xlen($sformatf("%s x%0d", test_name, rd), exp, rs1_data);
    endtask

    // Both read ports against the model
    task automatic check_regs();
        for (int i = 0; i < 32; i++) begin
            if (hung) begin
                return;
            end
            @(posedge clk);
            #1;
            rs1_addr = rv_isa_pkg::reg_addr_t'(i);
            rs2_addr = rv_isa_pkg::reg_addr_t'(31 - i);
            #1;
            check_xlen($sformatf("%s rs1 x%0d", test_name, i), model_regs[i], rs1_data);
            check_xlen($sformatf("%s rs2 x%0d", test_name, 31 - i), model_regs[31 - i],
                       rs2_data);
        end
    endtask

    task automatic test_reset();
        start_test("reset");
        check_bit("reset pc_wen_o", 1'b0, pc_wen);
        check_regs();
        end_test();
    endtask

    task automatic test_alu_write();
        rv_isa_pkg::reg_addr_t rd;
        rv_isa_pkg::xlen_t     res;
        start_test("alu_write");
        for (int k = 0; k < 8; k++) begin
            rd  = rv_isa_pkg::reg_addr_t'($urandom_range(31, 1));
            res = $urandom();
            issue_inst(opcode_at(k % 4), rd, rand_pc(), res, ~res);
            check_reg(rd, res);
        end
        end_test();
    endtask

    task automatic test_load_write();
        rv_isa_pkg::reg_addr_t rd;
        rv_isa_pkg::xlen_t     data;
        start_test("load_write");
        for (int k = 0; k < 3; k++) begin
            rd   = rv_isa_pkg::reg_addr_t'($urandom_range(31, 1));
            data = $urandom();
            issue_inst(rv_isa_pkg::OPC_LOAD, rd, rand_pc(), data ^ 32'h5a5a_0f0f, data);
            check_reg(rd, data);
        end
        end_test();
    endtask

    task automatic test_jumps();
        rv_isa_pkg::reg_addr_t rd;
        rv_isa_pkg::xlen_t     pc;
        start_test("jumps");
        rd = rv_isa_pkg::reg_addr_t'($urandom_range(31, 1));
        pc = rand_pc();
        issue_inst(rv_isa_pkg::OPC_JAL, rd, pc, $urandom(), $urandom());
        check_reg(rd, pc + 32'd4);
        // Return address wraps at the top of the address space
        rd = rv_isa_pkg::reg_addr_t'($urandom_range(31, 1));
        issue_inst(rv_isa_pkg::OPC_JALR, rd, 32'hffff_fffc, $urandom(), $urandom());
        check_reg(rd, 32'h0000_0000);
        end_test();
    endtask

    task automatic test_no_write();
        start_test("no_write");
        issue_inst(rv_isa_pkg::OPC_STORE, 5'd3, rand_pc(), $urandom(), $urandom());
        issue_inst(rv_isa_pkg::OPC_BRANCH, 5'd7, rand_pc(), $urandom(), $urandom());
        issue_inst(rv_isa_pkg::OPC_SYSTEM, 5'd31, rand_pc(), $urandom(), $urandom());
        issue_inst(rv_isa_pkg::OPC_LUI, 5'd0, rand_pc(), $urandom(), $urandom());
        issue_inst(rv_isa_pkg::OPC_LOAD, 5'd0, rand_pc(), $urandom(), $urandom());
        issue_inst(rv_isa_pkg::OPC_JAL, 5'd0, rand_pc(), $urandom(), $urandom());
        check_regs();
        end_test();
    endtask

    task automatic test_held_and_stream();
        rv_isa_pkg::reg_addr_t rd;
        rv_isa_pkg::xlen_t     res;
        rv_isa_pkg::xlen_t     pc;
        int                    pulses;
        start_test("held_and_stream");
        rd  = rv_isa_pkg::reg_addr_t'($urandom_range(31, 1));
        res = $urandom();
        pc  = rand_pc();
        @(posedge clk);
        #1;
        mem_wb.pc         = pc;
        mem_wb.inst       = {25'h0, rv_isa_pkg::OPC_OP};
        mem_wb.result     = res;
        mem_wb.dmem_rdata = ~res;
        mem_wb.rd         = rd;
        mem_valid         = 1'b1;
        pulses            = 0;
        repeat (10) begin
            @(posedge clk);
            #1;
            if (pc_wen) begin
                pulses++;
            end
        end
        mem_valid = 1'b0;
        update_model(rv_isa_pkg::OPC_OP, rd, pc, res, ~res);
        check_xlen("held valid pulses", 32'd1, rv_isa_pkg::xlen_t'(pulses));
        check_reg(rd, res);
        for (int k = 0; k < 40; k++) begin
            issue_inst(opcode_at($urandom_range(0, 10)),
                       rv_isa_pkg::reg_addr_t'($urandom_range(0, 31)),
                       rand_pc(), $urandom(), $urandom());
            if (k % 10 == 9) begin
                check_regs();
            end
        end
        end_test();
    endtask

    initial begin
        void'($urandom(32'h7bab));
        clk       = 1'b0;
        rst       = 1'b1;
        mem_wb    = '0;
        mem_valid = 1'b0;
        rs1_addr  = '0;
        rs2_addr  = '0;
        n_checks  = 0;
        n_errors  = 0;
        n_tests   = 0;
        n_failed  = 0;
        hung      = 1'b0;
        for (int i = 0; i < 32; i++) begin
            model_regs[i] = '0;
        end
        repeat (16) @(posedge clk);
        #1;
        rst = 1'b0;

        test_reset();
        test_alu_write();
        test_load_write();
        test_jumps();
        test_no_write();
        test_held_and_stream();

        $display("Summary: %0d tests, %0d failed, %0d checks, %0d errors, %0d assertion errors",
                 n_tests, n_failed, n_checks, n_errors, UUT.u_wb_stage.u_chk.fail_cnt);
        if (hung || n_errors != 0 || UUT.u_wb_stage.u_chk.fail_cnt != 0) begin
            $display("TEST FAIL");
        end else begin
            $display("TEST PASS");
        end
        $finish;
    end

endmodule : wb_tb

`default_nettype wire

// File: list.f
source/rv_isa_pkg.sv
source/wb_pkg.sv
source/wb_decode.sv
source/wb_stage.sv
source/reg_file.sv
source/wb_top.sv
sim/wb_chk.sv
sim/wb_tb.sv

// File: Bender.yml
package:
  name: rv_wb_stage

sources:
  # Packages first, then the design bottom up
  - files:
      - source/rv_isa_pkg.sv
      - source/wb_pkg.sv
      - source/wb_decode.sv
      - source/wb_stage.sv
      - source/reg_file.sv
      - source/wb_top.sv

  - target: simulation
    files:
      - sim/wb_chk.sv
      - sim/wb_tb.sv
